// ==== audio_dac.sv ====
`include "cart_config.svh"

module audio_dac
	import cart_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst,
	input  sample_t sample,
	output logic    dac_out
);
	// one extra bit on top holds the carry of the last addition
	logic [`DAC_BITS:0] acc;

	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[`DAC_BITS-1:0]} + {1'b0, sample};
	end

	// the carry rate equals sample over 2**DAC_BITS
	assign dac_out = acc[`DAC_BITS];

endmodule

// ==== axil_download_regs.sv ====
`include "cart_config.svh"

module axil_download_regs
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	output store_wr_t  wr,
	output logic       wr_req,
	input  logic       wr_ack,
	output logic       download,
	output logic       soft_reset,
	input  logic       loaded
);
	axil_state_t state;
	rom_addr_t byte_addr;
	logic busy;
	logic data_wr;
	axil_data_t rd_mux;

	// a toggle is outstanding until the store copies it back
	assign busy = wr_req != wr_ack;

	assign awready = state == axil_store;
	assign wready = state == axil_store;
	assign bvalid = state == axil_resp;
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	assign data_wr = awready && awaddr == `REG_DATA && wstrb[0] && download;

	////////////////////////////////////////////////////////////
	// write channel
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= axil_idle;
		end else begin
			case (state)
				axil_idle: begin
					if (awvalid && wvalid && !busy)
						state <= axil_store;
				end
				axil_store: begin
					state <= axil_resp;
				end
				axil_resp: begin
					if (bready)
						state <= axil_idle;
				end
				default: begin
					state <= axil_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			download <= 1'b0;
			soft_reset <= 1'b0;
			byte_addr <= '0;
			wr_req <= 1'b0;
		end else if (awready) begin
			if (awaddr == `REG_CTRL && wstrb[0]) begin
				download <= wdata[0];
				soft_reset <= wdata[1];
				// a new download always starts at the bottom of the rom
				if (wdata[0])
					byte_addr <= '0;
			end
			if (data_wr) begin
				wr_req <= ~wr_req;
				byte_addr <= byte_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_wr) begin
			wr.addr <= byte_addr[`ROM_ADDR_BITS-1:1];
			wr.lane <= {byte_addr[0], ~byte_addr[0]};
			wr.data <= {2{wdata[7:0]}};
		end
	end

	////////////////////////////////////////////////////////////
	// read channel
	////////////////////////////////////////////////////////////

	always_comb begin
		case (araddr)
			`REG_CTRL: rd_mux = {30'd0, soft_reset, download};
			`REG_STATUS: rd_mux = {byte_addr, 14'd0, busy, loaded};
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else if (arvalid && arready) begin
			arready <= 1'b0;
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
			arready <= 1'b1;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (arvalid && arready)
			rdata <= rd_mux;
	end

	// the host must never get a write through while the store still owes an ack
	assert property (@(posedge clk_sys) disable iff (rst) awready |-> wr_req == wr_ack);

endmodule

// ==== cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

////////////////////////////////////////////////////////////
// rom geometry
////////////////////////////////////////////////////////////

// the store holds one 16-bit word per two byte addresses
`define ROM_ADDR_BITS 16
`define ROM_WORDS 32768

////////////////////////////////////////////////////////////
// register offsets of the loader
////////////////////////////////////////////////////////////

`define REG_CTRL 4'h0
`define REG_DATA 4'h4
`define REG_STATUS 4'h8

`define DAC_BITS 4

`endif

// ==== cart_pkg.sv ====
`include "cart_config.svh"

package cart_pkg;

	////////////////////////////////////////////////////////////
	// rom side
	////////////////////////////////////////////////////////////

	typedef logic [`ROM_ADDR_BITS-1:0] rom_addr_t;
	typedef logic [`ROM_ADDR_BITS-2:0] word_addr_t;
	typedef logic [7:0] rom_byte_t;
	typedef logic [15:0] rom_word_t;

	// bit 0 is the low byte, which holds the even address
	typedef logic [1:0] lane_t;

	////////////////////////////////////////////////////////////
	// host and audio side
	////////////////////////////////////////////////////////////

	typedef logic [3:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [`DAC_BITS-1:0] sample_t;

	// the byte sits in both halves, the lane picks the one that is written
	typedef struct packed {
		word_addr_t addr;
		lane_t lane;
		rom_word_t data;
	} store_wr_t;

	typedef enum logic [1:0] {
		axil_idle,
		axil_store,
		axil_resp
	} axil_state_t;

endpackage

// ==== cart_reset_ctrl.sv ====
module cart_reset_ctrl (
	input  logic clk_sys,
	input  logic rst,
	input  logic download,
	input  logic soft_reset,
	input  logic reset_button,
	output logic loaded,
	output logic cpu_reset
);
	logic download_d;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			download_d <= 1'b0;
			loaded <= 1'b0;
			cpu_reset <= 1'b1;
		end else begin
			download_d <= download;
			// the rom image is complete once download falls
			if (download_d && !download)
				loaded <= 1'b1;
			cpu_reset <= soft_reset | reset_button | ~loaded;
		end
	end

	// once a rom is in place it stays valid until a system reset
	assert property (@(posedge clk_sys) disable iff (rst)
		!$past(rst) && $past(loaded) |-> loaded);

endmodule

// ==== cart_subsystem_top.sv ====
module cart_subsystem_top
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	input  logic       reset_button,
	input  rom_addr_t  cpu_addr,
	output rom_byte_t  cpu_data,
	output logic       cpu_reset,
	input  sample_t    audio_ch1,
	input  sample_t    audio_ch2,
	output logic       audio_l,
	output logic       audio_r
);
	store_wr_t wr;
	logic wr_req;
	logic wr_ack;
	logic download;
	logic soft_reset;
	logic loaded;

	////////////////////////////////////////////////////////////
	// host loader, rom and cpu reset
	////////////////////////////////////////////////////////////

	axil_download_regs u_regs (
		.clk_sys(clk_sys), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.wr(wr), .wr_req(wr_req), .wr_ack(wr_ack),
		.download(download), .soft_reset(soft_reset), .loaded(loaded)
	);

	rom_store u_store (
		.clk_sys(clk_sys), .rst(rst),
		.wr(wr), .wr_req(wr_req), .wr_ack(wr_ack),
		.download(download),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data)
	);

	cart_reset_ctrl u_reset (
		.clk_sys(clk_sys), .rst(rst),
		.download(download), .soft_reset(soft_reset), .reset_button(reset_button),
		.loaded(loaded), .cpu_reset(cpu_reset)
	);

	////////////////////////////////////////////////////////////
	// audio channels cross over as on the board
	////////////////////////////////////////////////////////////

	audio_dac dac_l (
		.clk_sys(clk_sys), .rst(rst), .sample(audio_ch2), .dac_out(audio_l)
	);

	audio_dac dac_r (
		.clk_sys(clk_sys), .rst(rst), .sample(audio_ch1), .dac_out(audio_r)
	);

endmodule

// ==== rom_store.sv ====
`include "cart_config.svh"

module rom_store
	import cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	input  store_wr_t wr,
	input  logic      wr_req,
	output logic      wr_ack,
	input  logic      download,
	input  rom_addr_t cpu_addr,
	output rom_byte_t cpu_data
);
	rom_word_t mem [`ROM_WORDS];
	word_addr_t rd_addr;
	rom_word_t rd_word;
	logic rd_hi;
	logic wr_hit;
	logic wr_pend;

	////////////////////////////////////////////////////////////
	// toggle handshake write port
	////////////////////////////////////////////////////////////

	// a new request shows up as a difference between req and ack
	assign wr_hit = wr_req != wr_ack && !wr_pend;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_pend <= 1'b0;
			wr_ack <= 1'b0;
		end else begin
			wr_pend <= wr_hit;
			// ack one cycle after the word was written
			if (wr_pend)
				wr_ack <= wr_req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			if (wr.lane[0])
				mem[wr.addr][7:0] <= wr.data[7:0];
			if (wr.lane[1])
				mem[wr.addr][15:8] <= wr.data[15:8];
		end
	end

	////////////////////////////////////////////////////////////
	// cpu read port
	////////////////////////////////////////////////////////////

	assign rd_addr = cpu_addr[`ROM_ADDR_BITS-1:1];

	// during a load the cpu sees an erased rom, as on the board
	always_ff @(posedge clk_sys) begin
		if (download)
			rd_word <= 16'hffff;
		else
			rd_word <= mem[rd_addr];
		rd_hi <= cpu_addr[0];
	end

	assign cpu_data = rd_hi ? rd_word[15:8] : rd_word[7:0];

	// the loader must always address one of the two bytes
	assert property (@(posedge clk_sys) disable iff (rst) wr_hit |-> wr.lane != 2'b00);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart -f tb.f -o sim_tb_cart

out=$(./obj_dir/sim_tb_cart)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi

// ==== tb.f ====
+incdir+.
cart_pkg.sv
axil_download_regs.sv
rom_store.sv
cart_reset_ctrl.sv
audio_dac.sv
cart_subsystem_top.sv
tb_clock.sv
tb_cart.sv

// ==== tb_cart.sv ====
`include "cart_config.svh"

module tb_cart
	import cart_pkg::*;
();
	localparam int wait_limit = 400;

	logic clk_sys;
	logic rst;
	axil_addr_t awaddr;
	logic awvalid;
	logic awready;
	axil_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	axil_addr_t araddr;
	logic arvalid;
	logic arready;
	axil_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic reset_button;
	rom_addr_t cpu_addr;
	rom_byte_t cpu_data;
	logic cpu_reset;
	sample_t audio_ch1;
	sample_t audio_ch2;
	logic audio_l;
	logic audio_r;

	// expected rom bytes indexed from address 0 where every download starts
	rom_byte_t model [256];
	int seed;
	int check_count;
	int error_count;
	int test_count;
	int test_fail_count;
	int test_errors_start;

	tb_clock #(.period(40)) u_clock (.clk_sys(clk_sys));

	cart_subsystem_top dut (.*);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		check_count = check_count + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("Test failed");
		$finish;
	endtask

	task automatic finish_test(input string name);
		test_count = test_count + 1;
		if (error_count == test_errors_start) begin
			$display("[%0t] %s: pass", $time, name);
		end else begin
			test_fail_count = test_fail_count + 1;
			$display("[%0t] %s: FAIL with %0d mismatches", $time, name,
				error_count - test_errors_start);
		end
		test_errors_start = error_count;
	endtask

	// all bus tasks start and end on a falling edge
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
		int cycles;
		cycles = 0;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(awready && wready)) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > wait_limit)
				abort_run("the register block never accepted an AXI write");
		end
		@(negedge clk_sys);
		awvalid = 1'b0;
		wvalid = 1'b0;
		cycles = 0;
		while (!bvalid) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > wait_limit)
				abort_run("no AXI write response arrived");
		end
		check_value(32'(bresp), 32'd0, "write response");
		@(negedge clk_sys);
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
		int cycles;
		cycles = 0;
		araddr = addr;
		arvalid = 1'b1;
		while (!arready) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > wait_limit)
				abort_run("the register block never accepted an AXI read");
		end
		@(negedge clk_sys);
		arvalid = 1'b0;
		cycles = 0;
		while (!rvalid) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > wait_limit)
				abort_run("no AXI read data arrived");
		end
		check_value(32'(rresp), 32'd0, "read response");
		data = rdata;
		@(negedge clk_sys);
	endtask

	task automatic wait_cpu_reset(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (cpu_reset !== level) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > wait_limit)
				abort_run(what);
		end
	endtask

	// the byte shows up one clock after the address
	task automatic rom_read(input rom_addr_t addr, output rom_byte_t data);
		cpu_addr = addr;
		@(negedge clk_sys);
		data = cpu_data;
	endtask

	task automatic download_bytes(input int count);
		axil_data_t data;
		for (int i = 0; i < count; i++) begin
			data = $random(seed);
			axil_write(`REG_DATA, data);
			model[i] = data[7:0];
		end
	endtask

	task automatic verify_rom();
		rom_byte_t got;
		for (int a = 0; a < 256; a++) begin
			rom_read(16'(a), got);
			check_value(32'(got), 32'(model[a]), $sformatf("rom byte at %0h", a));
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	initial begin
		axil_data_t rd;
		rom_byte_t got;
		int rnd;
		int ones_l;
		int ones_r;
		seed = 49;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		test_fail_count = 0;
		test_errors_start = 0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		reset_button = 1'b0;
		cpu_addr = '0;
		audio_ch1 = '0;
		audio_ch2 = '0;

		repeat (8) @(negedge clk_sys);
		check_value(32'({awready, wready, bvalid, arready, rvalid}), 32'd0,
			"handshake outputs during reset");
		check_value(32'(dut.wr_req), 32'(dut.wr_ack), "toggle pair during reset");
		check_value(32'({audio_l, audio_r}), 32'd0, "dac outputs during reset");
		rst = 1'b0;
		@(negedge clk_sys);
		check_value(32'(arready), 32'd1, "arready one cycle after reset");
		check_value(32'(cpu_reset), 32'd1, "cpu_reset after reset");
		axil_read(`REG_STATUS, rd);
		check_value(32'(rd[0]), 32'd0, "loaded bit after reset");
		check_value(rd, 32'd0, "status after reset");
		axil_read(4'hc, rd);
		check_value(rd, 32'd0, "unmapped offset");
		finish_test("reset defaults");

		axil_write(`REG_CTRL, 32'h1);
		download_bytes(256);
		axil_write(`REG_CTRL, 32'h0);
		axil_read(`REG_STATUS, rd);
		check_value(32'(rd[0]), 32'd1, "loaded after download");
		check_value(32'(rd[1]), 32'd0, "busy after download");
		check_value(32'(rd[31:16]), 32'd256, "next byte address after download");
		finish_test("rom download");

		wait_cpu_reset(1'b0, "cpu_reset did not fall after the download");
		axil_write(`REG_CTRL, 32'h2);
		wait_cpu_reset(1'b1, "cpu_reset did not rise on soft reset");
		axil_write(`REG_CTRL, 32'h0);
		wait_cpu_reset(1'b0, "cpu_reset did not fall after soft reset");
		reset_button = 1'b1;
		wait_cpu_reset(1'b1, "cpu_reset did not rise on the reset button");
		reset_button = 1'b0;
		wait_cpu_reset(1'b0, "cpu_reset did not fall after the reset button");
		finish_test("cpu reset release");

		// alternate even and odd bytes so both lanes are read back
		for (int i = 0; i < 64; i++) begin
			rnd = $random(seed);
			rom_read({8'd0, rnd[7:1], i[0]}, got);
			check_value(32'(got), 32'(model[{rnd[7:1], i[0]}]),
				$sformatf("cpu fetch at %0h", {rnd[7:1], i[0]}));
		end
		finish_test("rom fetch");

		axil_write(`REG_DATA, $random(seed));
		axil_read(`REG_STATUS, rd);
		check_value(rd, {16'd256, 16'h0001}, "status after locked-out data write");
		verify_rom();
		axil_write(`REG_CTRL, 32'h1);
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			rom_read(16'(rnd[7:0]), got);
			check_value(32'(got), 32'hff, "cpu data during download");
		end
		download_bytes(64);
		rom_read(16'h0001, got);
		check_value(32'(got), 32'hff, "cpu data late in download");
		axil_write(`REG_CTRL, 32'h0);
		axil_read(`REG_STATUS, rd);
		check_value(rd, {16'd64, 16'h0001}, "status after second download");
		verify_rom();
		finish_test("download lock-out and restart");

		// first round pins the extremes, so a swapped pair cannot pass
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			audio_ch1 = (i == 0) ? 4'hf : rnd[3:0];
			audio_ch2 = (i == 0) ? 4'h0 : rnd[7:4];
			ones_l = 0;
			ones_r = 0;
			repeat (2) @(negedge clk_sys);
			for (int b = 0; b < 16; b++) begin
				ones_r = ones_r + int'(audio_r);
				ones_l = ones_l + int'(audio_l);
				@(negedge clk_sys);
			end
			check_value(32'(ones_r), 32'(audio_ch1), $sformatf("audio_r ones, ch1 %0d", audio_ch1));
			check_value(32'(ones_l), 32'(audio_ch2), $sformatf("audio_l ones, ch2 %0d", audio_ch2));
		end
		finish_test("audio dacs");

		$display("%0d tests run, %0d failed, %0d checks, %0d mismatches",
			test_count, test_fail_count, check_count, error_count);
		if (error_count == 0 && test_fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
	parameter int period = 40
) (
	output logic clk_sys
);
	initial begin
		clk_sys = 1'b0;
	end

	always begin
		#(period / 2) clk_sys = ~clk_sys;
	end

endmodule
